// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/dc_geom_pkg.sv
// Data cache geometry
// Width helpers that derive the address fields and the word size
// from the cache size, the line size and the address width
package dc_geom_pkg;

    // Byte offset bits within a line
    function automatic int dc_offset_width(input int line_size);
        return $clog2(line_size);
    endfunction

    // Line index bits, kept at one bit when the cache has a single line
    function automatic int dc_index_width(input int cache_size, input int line_size);
        int lines;
        lines = cache_size / line_size;
        return (lines > 1) ? $clog2(lines) : 1;
    endfunction

    function automatic int dc_tag_width(input int addr_width, input int cache_size,
                                        input int line_size);
        return addr_width - dc_offset_width(line_size)
               - dc_index_width(cache_size, line_size);
    endfunction

    function automatic int dc_word_bytes(input int data_width);
        return data_width / 8;
    endfunction

endpackage

// File: logic/dc_op_pkg.sv
// Data cache memory operations
// Load and store encodings with helpers for size, sign and direction
package dc_op_pkg;

    typedef enum logic [2:0] {
        DC_OP_LB, DC_OP_LH, DC_OP_LW, DC_OP_LBU,
        DC_OP_LHU, DC_OP_SB, DC_OP_SH, DC_OP_SW
    } dc_op_t;

    // Access size in bytes
    function automatic int dc_op_size(input dc_op_t op);
        case (op)
            DC_OP_LB, DC_OP_LBU, DC_OP_SB: return 1;
            DC_OP_LH, DC_OP_LHU, DC_OP_SH: return 2;
            default:                       return 4;
        endcase
    endfunction

    function automatic logic dc_op_signed(input dc_op_t op);
        return op inside {DC_OP_LB, DC_OP_LH, DC_OP_LW};
    endfunction

    function automatic logic dc_op_is_store(input dc_op_t op);
        return op inside {DC_OP_SB, DC_OP_SH, DC_OP_SW};
    endfunction

endpackage

// File: logic/dcache.sv
`timescale 1ns/1ps

// Level-one data cache, direct-mapped and write-back
// The DT stage and the array read work side by side, then DW resolves
// hit, load data, the array write and the victim line
module dcache
    import dc_geom_pkg::*, dc_op_pkg::*;
#(
    parameter int DATA_WIDTH   = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int CACHE_SIZE   = 1024,
    parameter int LINE_SIZE    = 32,
    localparam int LINE_WIDTH = LINE_SIZE * 8
)(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_dc_en,
    input  logic [ADDR_WIDTH-1:0] i_dc_addr,
    input  dc_op_t                i_dc_op,
    input  logic                  i_dc_wr_en,
    input  logic [DATA_WIDTH-1:0] i_dc_data,
    input  logic                  i_dc_fill,
    input  logic                  i_dc_dirty,
    input  logic [LINE_WIDTH-1:0] i_dc_fill_data,
    output logic [LINE_SIZE-1:0]  o_dc_dt_byte_sel,
    output logic                  o_dc_hit,
    output logic [DATA_WIDTH-1:0] o_dc_data,
    output logic                  o_dc_victim_valid,
    output logic [ADDR_WIDTH-1:0] o_dc_victim_addr,
    output logic [LINE_WIDTH-1:0] o_dc_victim_data
);

    localparam int OFFSET_W   = dc_offset_width(LINE_SIZE);
    localparam int INDEX_W    = dc_index_width(CACHE_SIZE, LINE_SIZE);
    localparam int TAG_W      = dc_tag_width(ADDR_WIDTH, CACHE_SIZE, LINE_SIZE);
    localparam int LINE_COUNT = CACHE_SIZE / LINE_SIZE;

    logic [INDEX_W-1:0]    rd_index;
    logic                  dt_en;
    logic                  dt_wr_en;
    logic                  dt_fill;
    logic                  dt_dirty;
    logic [TAG_W-1:0]      dt_tag;
    logic [INDEX_W-1:0]    dt_index;
    logic [OFFSET_W-1:0]   dt_offset;
    dc_op_t                dt_op;
    logic [LINE_SIZE-1:0]  dt_byte_sel;
    logic [LINE_WIDTH-1:0] dt_data;
    logic [LINE_WIDTH-1:0] dt_fill_data;
    logic                  rd_valid;
    logic                  rd_dirty;
    logic [TAG_W-1:0]      rd_tag;
    logic [LINE_WIDTH-1:0] rd_line;
    logic                  wr_en;
    logic [INDEX_W-1:0]    wr_index;
    logic                  wr_valid;
    logic                  wr_dirty;
    logic [TAG_W-1:0]      wr_tag;
    logic [LINE_WIDTH-1:0] wr_line;

    // Array read starts at the same edge that DT registers the request
    if (LINE_COUNT > 1) begin : g_rd_index
        assign rd_index = i_dc_addr[OFFSET_W +: INDEX_W];
    end else begin : g_rd_one_line
        assign rd_index = '0;
    end

    assign o_dc_dt_byte_sel = dt_byte_sel;

    dcache_dt #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .LINE_SIZE(LINE_SIZE)
    ) dt_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_en(i_dc_en),
        .i_wr_en(i_dc_wr_en),
        .i_addr(i_dc_addr),
        .i_op(i_dc_op),
        .i_data(i_dc_data),
        .i_fill(i_dc_fill),
        .i_dirty(i_dc_dirty),
        .i_fill_data(i_dc_fill_data),
        .o_en(dt_en),
        .o_wr_en(dt_wr_en),
        .o_fill(dt_fill),
        .o_dirty(dt_dirty),
        .o_tag(dt_tag),
        .o_index(dt_index),
        .o_offset(dt_offset),
        .o_op(dt_op),
        .o_byte_sel(dt_byte_sel),
        .o_data(dt_data),
        .o_fill_data(dt_fill_data)
    );

    dcache_array #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .LINE_SIZE(LINE_SIZE)
    ) array_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_rd_index(rd_index),
        .i_wr_en(wr_en),
        .i_wr_index(wr_index),
        .i_wr_valid(wr_valid),
        .i_wr_dirty(wr_dirty),
        .i_wr_tag(wr_tag),
        .i_wr_line(wr_line),
        .o_rd_valid(rd_valid),
        .o_rd_dirty(rd_dirty),
        .o_rd_tag(rd_tag),
        .o_rd_line(rd_line)
    );

    dcache_dw #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .LINE_SIZE(LINE_SIZE)
    ) dw_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_en(dt_en),
        .i_wr_en(dt_wr_en),
        .i_fill(dt_fill),
        .i_dirty(dt_dirty),
        .i_tag(dt_tag),
        .i_index(dt_index),
        .i_offset(dt_offset),
        .i_op(dt_op),
        .i_byte_sel(dt_byte_sel),
        .i_data(dt_data),
        .i_fill_data(dt_fill_data),
        .i_rd_valid(rd_valid),
        .i_rd_dirty(rd_dirty),
        .i_rd_tag(rd_tag),
        .i_rd_line(rd_line),
        .o_wr_en(wr_en),
        .o_wr_index(wr_index),
        .o_wr_valid(wr_valid),
        .o_wr_dirty(wr_dirty),
        .o_wr_tag(wr_tag),
        .o_wr_line(wr_line),
        .o_hit(o_dc_hit),
        .o_data(o_dc_data),
        .o_victim_valid(o_dc_victim_valid),
        .o_victim_addr(o_dc_victim_addr),
        .o_victim_data(o_dc_victim_data)
    );

endmodule

// File: logic/dcache_array.sv
`timescale 1ns/1ps

// Direct-mapped data cache array
// Valid and dirty flags in flops, tags and line data in memories
// The read port returns the old line when it meets a write to the same index
module dcache_array
    import dc_geom_pkg::*;
#(
    parameter int ADDR_WIDTH   = 32,
    parameter int CACHE_SIZE   = 1024,
    parameter int LINE_SIZE    = 32,
    localparam int INDEX_W    = dc_index_width(CACHE_SIZE, LINE_SIZE),
    localparam int TAG_W      = dc_tag_width(ADDR_WIDTH, CACHE_SIZE, LINE_SIZE),
    localparam int LINE_WIDTH = LINE_SIZE * 8
)(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic [INDEX_W-1:0]    i_rd_index,
    input  logic                  i_wr_en,
    input  logic [INDEX_W-1:0]    i_wr_index,
    input  logic                  i_wr_valid,
    input  logic                  i_wr_dirty,
    input  logic [TAG_W-1:0]      i_wr_tag,
    input  logic [LINE_WIDTH-1:0] i_wr_line,
    output logic                  o_rd_valid,
    output logic                  o_rd_dirty,
    output logic [TAG_W-1:0]      o_rd_tag,
    output logic [LINE_WIDTH-1:0] o_rd_line
);

    localparam int LINE_COUNT = CACHE_SIZE / LINE_SIZE;

    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;
    logic [TAG_W-1:0]      tag_mem  [LINE_COUNT];
    logic [LINE_WIDTH-1:0] line_mem [LINE_COUNT];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            o_rd_valid <= 1'b0;
            o_rd_dirty <= 1'b0;
        end else begin
            if (i_wr_en) begin
                valid_q[i_wr_index] <= i_wr_valid;
                dirty_q[i_wr_index] <= i_wr_dirty;
            end
            o_rd_valid <= valid_q[i_rd_index];
            o_rd_dirty <= dirty_q[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
        o_rd_tag  <= tag_mem[i_rd_index];
        o_rd_line <= line_mem[i_rd_index];
    end

endmodule

// File: logic/dcache_dt.sv
`timescale 1ns/1ps

// Data cache DT stage
// Registers the request and splits the address into tag, index and offset
// Store data and byte enables are moved to their byte position in the line
module dcache_dt
    import dc_geom_pkg::*, dc_op_pkg::*;
#(
    parameter int DATA_WIDTH   = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int CACHE_SIZE   = 1024,
    parameter int LINE_SIZE    = 32,
    localparam int OFFSET_W   = dc_offset_width(LINE_SIZE),
    localparam int INDEX_W    = dc_index_width(CACHE_SIZE, LINE_SIZE),
    localparam int TAG_W      = dc_tag_width(ADDR_WIDTH, CACHE_SIZE, LINE_SIZE),
    localparam int LINE_WIDTH = LINE_SIZE * 8
)(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_en,
    input  logic                  i_wr_en,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  dc_op_t                i_op,
    input  logic [DATA_WIDTH-1:0] i_data,
    input  logic                  i_fill,
    input  logic                  i_dirty,
    input  logic [LINE_WIDTH-1:0] i_fill_data,
    output logic                  o_en,
    output logic                  o_wr_en,
    output logic                  o_fill,
    output logic                  o_dirty,
    output logic [TAG_W-1:0]      o_tag,
    output logic [INDEX_W-1:0]    o_index,
    output logic [OFFSET_W-1:0]   o_offset,
    output dc_op_t                o_op,
    output logic [LINE_SIZE-1:0]  o_byte_sel,
    output logic [LINE_WIDTH-1:0] o_data,
    output logic [LINE_WIDTH-1:0] o_fill_data
);

    localparam int LINE_COUNT = CACHE_SIZE / LINE_SIZE;
    localparam int WORD_BYTES = dc_word_bytes(DATA_WIDTH);

    logic [INDEX_W-1:0]    index;
    logic [WORD_BYTES-1:0] word_mask;
    logic [LINE_SIZE-1:0]  byte_sel;
    logic [LINE_WIDTH-1:0] line_data;

    if (LINE_COUNT > 1) begin : g_index
        assign index = i_addr[OFFSET_W +: INDEX_W];
    end else begin : g_one_line
        // No index bits with a single line
        assign index = '0;
    end

    // Size mask of the access, moved up to the byte offset in the line
    always_comb begin
        word_mask = WORD_BYTES'((1 << dc_op_size(i_op)) - 1);
        byte_sel  = LINE_SIZE'(word_mask) << i_addr[OFFSET_W-1:0];
        line_data = LINE_WIDTH'(i_data) << {i_addr[OFFSET_W-1:0], 3'b000};
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_en    <= 1'b0;
            o_wr_en <= 1'b0;
        end else begin
            o_en    <= i_en;
            o_wr_en <= i_en & i_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        o_fill      <= i_fill;
        o_dirty     <= i_dirty;
        o_tag       <= i_addr[ADDR_WIDTH-1 -: TAG_W];
        o_index     <= index;
        o_offset    <= i_addr[OFFSET_W-1:0];
        o_op        <= i_op;
        o_byte_sel  <= byte_sel;
        o_data      <= line_data;
        o_fill_data <= i_fill_data;
    end

endmodule

// File: logic/dcache_dw.sv
`timescale 1ns/1ps

// Data cache DW stage
// Resolves hit against the line read in DT, builds the array write for
// store hits and fills, and registers load data and the evicted line
module dcache_dw
    import dc_geom_pkg::*, dc_op_pkg::*;
#(
    parameter int DATA_WIDTH   = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int CACHE_SIZE   = 1024,
    parameter int LINE_SIZE    = 32,
    localparam int OFFSET_W   = dc_offset_width(LINE_SIZE),
    localparam int INDEX_W    = dc_index_width(CACHE_SIZE, LINE_SIZE),
    localparam int TAG_W      = dc_tag_width(ADDR_WIDTH, CACHE_SIZE, LINE_SIZE),
    localparam int LINE_WIDTH = LINE_SIZE * 8
)(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_en,
    input  logic                  i_wr_en,
    input  logic                  i_fill,
    input  logic                  i_dirty,
    input  logic [TAG_W-1:0]      i_tag,
    input  logic [INDEX_W-1:0]    i_index,
    input  logic [OFFSET_W-1:0]   i_offset,
    input  dc_op_t                i_op,
    input  logic [LINE_SIZE-1:0]  i_byte_sel,
    input  logic [LINE_WIDTH-1:0] i_data,
    input  logic [LINE_WIDTH-1:0] i_fill_data,
    input  logic                  i_rd_valid,
    input  logic                  i_rd_dirty,
    input  logic [TAG_W-1:0]      i_rd_tag,
    input  logic [LINE_WIDTH-1:0] i_rd_line,
    output logic                  o_wr_en,
    output logic [INDEX_W-1:0]    o_wr_index,
    output logic                  o_wr_valid,
    output logic                  o_wr_dirty,
    output logic [TAG_W-1:0]      o_wr_tag,
    output logic [LINE_WIDTH-1:0] o_wr_line,
    output logic                  o_hit,
    output logic [DATA_WIDTH-1:0] o_data,
    output logic                  o_victim_valid,
    output logic [ADDR_WIDTH-1:0] o_victim_addr,
    output logic [LINE_WIDTH-1:0] o_victim_data
);

    localparam int WORD_BYTES = dc_word_bytes(DATA_WIDTH);

    // Copy of the write issued last cycle, which the array read missed
    logic                  fwd_en_q;
    logic [INDEX_W-1:0]    fwd_index_q;
    logic                  fwd_dirty_q;
    logic [TAG_W-1:0]      fwd_tag_q;
    logic [LINE_WIDTH-1:0] fwd_line_q;

    logic                  use_fwd;
    logic                  eff_valid;
    logic                  eff_dirty;
    logic [TAG_W-1:0]      eff_tag;
    logic [LINE_WIDTH-1:0] eff_line;
    logic                  hit;
    logic                  fill_wr;
    logic [LINE_WIDTH-1:0] merged_line;
    logic [LINE_WIDTH-1:0] shifted_line;
    logic [DATA_WIDTH-1:0] load_data;

    assign use_fwd   = fwd_en_q && (fwd_index_q == i_index);
    // A forwarded write always leaves the line valid
    assign eff_valid = use_fwd || i_rd_valid;
    assign eff_dirty = use_fwd ? fwd_dirty_q : i_rd_dirty;
    assign eff_tag   = use_fwd ? fwd_tag_q : i_rd_tag;
    assign eff_line  = use_fwd ? fwd_line_q : i_rd_line;

    assign hit     = i_en && !i_fill && eff_valid && (eff_tag == i_tag);
    assign fill_wr = i_en && i_wr_en && i_fill;

    // Store bytes replace line bytes under the byte select
    always_comb begin
        for (int b = 0; b < LINE_SIZE; b++) begin
            merged_line[b*8 +: 8] = i_byte_sel[b] ? i_data[b*8 +: 8] : eff_line[b*8 +: 8];
        end
    end

    // Only store hits and fills reach the array
    assign o_wr_en    = fill_wr || (hit && i_wr_en);
    assign o_wr_index = i_index;
    assign o_wr_valid = 1'b1;
    assign o_wr_dirty = i_fill ? i_dirty : 1'b1;
    assign o_wr_tag   = i_tag;
    assign o_wr_line  = i_fill ? i_fill_data : merged_line;

    always_comb begin
        int   size;
        logic sign_bit;
        size         = dc_op_size(i_op);
        shifted_line = eff_line >> {i_offset, 3'b000};
        load_data    = shifted_line[DATA_WIDTH-1:0];
        sign_bit     = dc_op_signed(i_op) && load_data[size*8-1];
        // Bytes above the access size take the sign or zero
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (b >= size) begin
                load_data[b*8 +: 8] = {8{sign_bit}};
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fwd_en_q       <= 1'b0;
            o_hit          <= 1'b0;
            o_victim_valid <= 1'b0;
        end else begin
            fwd_en_q       <= o_wr_en;
            o_hit          <= hit;
            o_victim_valid <= fill_wr && eff_valid && eff_dirty;
        end
    end

    always_ff @(posedge clk) begin
        fwd_index_q   <= o_wr_index;
        fwd_dirty_q   <= o_wr_dirty;
        fwd_tag_q     <= o_wr_tag;
        fwd_line_q    <= o_wr_line;
        o_data        <= (hit && !dc_op_is_store(i_op)) ? load_data : '0;
        o_victim_addr <= {eff_tag, i_index, {OFFSET_W{1'b0}}};
        o_victim_data <= eff_line;
    end

endmodule

// File: src.f
logic/dc_geom_pkg.sv
logic/dc_op_pkg.sv
logic/dcache_dt.sv
logic/dcache_array.sv
logic/dcache_dw.sv
logic/dcache.sv
test/dcache_checker.sv
test/dcache_tb.sv

// File: test/dcache_checker.sv
`timescale 1ns/1ps

// Data cache checker
// Queues expected results as requests enter the cache, then compares the
// byte select one cycle later and hit, load data and victim two cycles later
module dcache_checker #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_SIZE  = 32,
    localparam int LINE_W    = LINE_SIZE * 8
)(
    input  logic                  clk,
    input  logic                  i_req_en,
    input  logic [LINE_SIZE-1:0]  i_exp_byte_sel,
    input  logic                  i_exp_hit,
    input  logic [DATA_WIDTH-1:0] i_exp_data,
    input  logic                  i_exp_victim_valid,
    input  logic [ADDR_WIDTH-1:0] i_exp_victim_addr,
    input  logic [LINE_W-1:0]     i_exp_victim_data,
    input  logic [LINE_SIZE-1:0]  i_byte_sel,
    input  logic                  i_hit,
    input  logic [DATA_WIDTH-1:0] i_data,
    input  logic                  i_victim_valid,
    input  logic [ADDR_WIDTH-1:0] i_victim_addr,
    input  logic [LINE_W-1:0]     i_victim_data,
    output int                    o_check_count,
    output int                    o_value_errors,
    output int                    o_other_errors,
    output int                    o_pending
);

    // Result entry: hit, load data, victim valid, victim address, victim line
    localparam int RES_W = 1 + DATA_WIDTH + 1 + ADDR_WIDTH + LINE_W;
    localparam int VV_BIT = ADDR_WIDTH + LINE_W;

    logic [LINE_SIZE-1:0] sel_q [$];
    logic [RES_W-1:0]     res_q [$];
    logic                 req_d1 = 1'b0;
    logic                 req_d2 = 1'b0;
    int                   push_count = 0;
    int                   pop_count = 0;
    int                   check_count = 0;
    int                   value_errors = 0;
    int                   other_errors = 0;

    assign o_check_count  = check_count;
    assign o_value_errors = value_errors;
    assign o_other_errors = other_errors;
    assign o_pending      = push_count - pop_count;

    task automatic check_value(input string name, input logic [LINE_W-1:0] expected,
                               input logic [LINE_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("error at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // Same sampling point as the DUT request registers
    always @(posedge clk) begin
        req_d1 <= i_req_en;
        req_d2 <= req_d1;
        if (i_req_en) begin
            sel_q.push_back(i_exp_byte_sel);
            res_q.push_back({i_exp_hit, i_exp_data, i_exp_victim_valid,
                             i_exp_victim_addr, i_exp_victim_data});
            push_count <= push_count + 1;
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        logic [RES_W-1:0] res;
        if (req_d1) begin
            if (sel_q.size() == 0) begin
                other_errors++;
                $display("byte select due at time %0t but nothing was queued", $time);
            end else begin
                check_value("o_dc_dt_byte_sel", LINE_W'(sel_q.pop_front()),
                            LINE_W'(i_byte_sel));
            end
        end
        if (req_d2) begin
            pop_count <= pop_count + 1;
            if (res_q.size() == 0) begin
                other_errors++;
                $display("result due at time %0t but nothing was queued", $time);
            end else begin
                res = res_q.pop_front();
                check_value("o_dc_hit", LINE_W'(res[RES_W-1]), LINE_W'(i_hit));
                check_value("o_dc_data", LINE_W'(res[RES_W-2 -: DATA_WIDTH]),
                            LINE_W'(i_data));
                check_value("o_dc_victim_valid", LINE_W'(res[VV_BIT]),
                            LINE_W'(i_victim_valid));
                if (res[VV_BIT]) begin
                    check_value("o_dc_victim_addr", LINE_W'(res[LINE_W +: ADDR_WIDTH]),
                                LINE_W'(i_victim_addr));
                    check_value("o_dc_victim_data", res[LINE_W-1:0], i_victim_data);
                end
            end
        end else begin
            // No request in DW, so nothing may be reported
            check_value("o_dc_hit", '0, LINE_W'(i_hit));
            check_value("o_dc_victim_valid", '0, LINE_W'(i_victim_valid));
        end
    end

endmodule

// File: test/dcache_tb.sv
`timescale 1ns/1ps

// Data cache testbench
// Random fills, stores and loads over a few tags and indices, with
// expected results from a line-level reference model of the cache
module dcache_tb
    import dc_geom_pkg::*, dc_op_pkg::*;
();

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int CACHE_SIZE     = 1024;
    localparam int LINE_SIZE      = 32;
    localparam int OFFSET_W       = dc_offset_width(LINE_SIZE);
    localparam int INDEX_W        = dc_index_width(CACHE_SIZE, LINE_SIZE);
    localparam int TAG_W          = dc_tag_width(ADDR_WIDTH, CACHE_SIZE, LINE_SIZE);
    localparam int LINE_W         = LINE_SIZE * 8;
    localparam int LINE_COUNT     = CACHE_SIZE / LINE_SIZE;
    localparam int NUM_REQ        = 600;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 2 + 100;

    logic                  clk;
    logic                  arst_n;
    logic                  dc_en;
    logic [ADDR_WIDTH-1:0] dc_addr;
    dc_op_t                dc_op;
    logic                  dc_wr_en;
    logic [DATA_WIDTH-1:0] dc_data;
    logic                  dc_fill;
    logic                  dc_dirty;
    logic [LINE_W-1:0]     dc_fill_data;
    logic [LINE_SIZE-1:0]  byte_sel;
    logic                  hit;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  victim_valid;
    logic [ADDR_WIDTH-1:0] victim_addr;
    logic [LINE_W-1:0]     victim_data;
    logic [LINE_SIZE-1:0]  exp_byte_sel;
    logic                  exp_hit;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_victim_valid;
    logic [ADDR_WIDTH-1:0] exp_victim_addr;
    logic [LINE_W-1:0]     exp_victim_data;
    int                    check_count;
    int                    value_errors;
    int                    other_errors;
    int                    pending;

    // Reference model of the cache contents
    logic              m_valid [LINE_COUNT];
    logic              m_dirty [LINE_COUNT];
    logic [TAG_W-1:0]  m_tag   [LINE_COUNT];
    logic [LINE_W-1:0] m_line  [LINE_COUNT];

    dcache #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .LINE_SIZE(LINE_SIZE)
    ) dut_i (
        .clk(clk),
        .i_arst_n(arst_n),
        .i_dc_en(dc_en),
        .i_dc_addr(dc_addr),
        .i_dc_op(dc_op),
        .i_dc_wr_en(dc_wr_en),
        .i_dc_data(dc_data),
        .i_dc_fill(dc_fill),
        .i_dc_dirty(dc_dirty),
        .i_dc_fill_data(dc_fill_data),
        .o_dc_dt_byte_sel(byte_sel),
        .o_dc_hit(hit),
        .o_dc_data(rdata),
        .o_dc_victim_valid(victim_valid),
        .o_dc_victim_addr(victim_addr),
        .o_dc_victim_data(victim_data)
    );

    dcache_checker #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .LINE_SIZE(LINE_SIZE)
    ) checker_i (
        .clk(clk),
        .i_req_en(dc_en),
        .i_exp_byte_sel(exp_byte_sel),
        .i_exp_hit(exp_hit),
        .i_exp_data(exp_data),
        .i_exp_victim_valid(exp_victim_valid),
        .i_exp_victim_addr(exp_victim_addr),
        .i_exp_victim_data(exp_victim_data),
        .i_byte_sel(byte_sel),
        .i_hit(hit),
        .i_data(rdata),
        .i_victim_valid(victim_valid),
        .i_victim_addr(victim_addr),
        .i_victim_data(victim_data),
        .o_check_count(check_count),
        .o_value_errors(value_errors),
        .o_other_errors(other_errors),
        .o_pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int access_bytes(input dc_op_t op);
        if (op == DC_OP_LW || op == DC_OP_SW) begin
            return 4;
        end
        if (op == DC_OP_LH || op == DC_OP_LHU || op == DC_OP_SH) begin
            return 2;
        end
        return 1;
    endfunction

    // Expected response of one request, applied to the model in request order
    function automatic void model_access(
        input  logic fill, input dc_op_t op, input logic [ADDR_WIDTH-1:0] addr,
        input  logic [DATA_WIDTH-1:0] wdata, input logic dirty,
        input  logic [LINE_W-1:0] fdata, output logic [LINE_SIZE-1:0] sel,
        output logic hit_e, output logic [DATA_WIDTH-1:0] data_e, output logic vv,
        output logic [ADDR_WIDTH-1:0] va, output logic [LINE_W-1:0] vd);
        int   idx;
        int   off;
        int   size;
        logic store;
        logic sign_bit;
        logic [TAG_W-1:0] tag;
        idx   = int'(addr[OFFSET_W +: INDEX_W]);
        off   = int'(addr[OFFSET_W-1:0]);
        tag   = addr[ADDR_WIDTH-1 -: TAG_W];
        size  = access_bytes(op);
        store = op == DC_OP_SB || op == DC_OP_SH || op == DC_OP_SW;
        sel   = LINE_SIZE'((1 << size) - 1) << off;
        hit_e = !fill && m_valid[idx] && (m_tag[idx] == tag);
        data_e = '0;
        vv    = fill && m_valid[idx] && m_dirty[idx];
        va    = {m_tag[idx], INDEX_W'(idx), OFFSET_W'(0)};
        vd    = m_line[idx];
        if (fill) begin
            m_valid[idx] = 1'b1;
            m_dirty[idx] = dirty;
            m_tag[idx]   = tag;
            m_line[idx]  = fdata;
        end else if (hit_e && store) begin
            for (int b = 0; b < size; b++) begin
                m_line[idx][(off + b) * 8 +: 8] = wdata[b * 8 +: 8];
            end
            m_dirty[idx] = 1'b1;
        end else if (hit_e) begin
            sign_bit = (op == DC_OP_LB || op == DC_OP_LH || op == DC_OP_LW)
                       && m_line[idx][(off + size) * 8 - 1];
            for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                data_e[b * 8 +: 8] = (b < size) ? m_line[idx][(off + b) * 8 +: 8]
                                                : {8{sign_bit}};
            end
        end
    endfunction

    task automatic send_request(input logic fill, input dc_op_t op,
                                input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] wdata, input logic dirty,
                                input logic [LINE_W-1:0] fdata);
        logic [LINE_SIZE-1:0]  sel;
        logic                  hit_e;
        logic [DATA_WIDTH-1:0] data_e;
        logic                  vv;
        logic [ADDR_WIDTH-1:0] va;
        logic [LINE_W-1:0]     vd;
        model_access(fill, op, addr, wdata, dirty, fdata, sel, hit_e, data_e, vv, va, vd);
        @(posedge clk);
        dc_en            <= 1'b1;
        dc_addr          <= addr;
        dc_op            <= op;
        dc_wr_en         <= fill || op == DC_OP_SB || op == DC_OP_SH || op == DC_OP_SW;
        dc_data          <= wdata;
        dc_fill          <= fill;
        dc_dirty         <= dirty;
        dc_fill_data     <= fdata;
        exp_byte_sel     <= sel;
        exp_hit          <= hit_e;
        exp_data         <= data_e;
        exp_victim_valid <= vv;
        exp_victim_addr  <= va;
        exp_victim_data  <= vd;
    endtask

    task automatic send_idle();
        @(posedge clk);
        dc_en    <= 1'b0;
        dc_wr_en <= 1'b0;
    endtask

    initial begin
        logic [LINE_W-1:0] fdata;
        logic [TAG_W-1:0]  tag;
        dc_op_t            op;
        int                kind;
        int                idx;
        int                prev_idx;
        int                off;
        void'($urandom(32'hfeaa032b));
        arst_n = 1'b0;
        dc_en = 1'b0;
        dc_addr = '0;
        dc_op = DC_OP_LW;
        dc_wr_en = 1'b0;
        dc_data = '0;
        dc_fill = 1'b0;
        dc_dirty = 1'b0;
        dc_fill_data = '0;
        for (int i = 0; i < LINE_COUNT; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_tag[i]   = '0;
            m_line[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        prev_idx = 0;
        for (int n = 0; n < NUM_REQ; n++) begin
            // Loads first so that the empty cache is seen to miss
            kind = (n < 8) ? 9 : int'($urandom_range(0, 9));
            if (kind < 2) begin
                op = DC_OP_LW;
            end else if (kind < 5) begin
                op = dc_op_t'(3'(5 + $urandom_range(0, 2)));
            end else begin
                op = dc_op_t'(3'($urandom_range(0, 4)));
            end
            // One request in three reuses the last index back to back
            idx = ($urandom_range(0, 2) != 0) ? int'($urandom_range(0, 7)) : prev_idx;
            prev_idx = idx;
            tag = TAG_W'(12'h5a0 + $urandom_range(0, 2));
            off = int'($urandom_range(0, LINE_SIZE - 1)) & ~(access_bytes(op) - 1);
            for (int w = 0; w < LINE_W / 32; w++) begin
                fdata[w * 32 +: 32] = $urandom();
            end
            if ($urandom_range(0, 7) == 0) begin
                send_idle();
            end
            send_request(kind < 2, op, {tag, INDEX_W'(idx), OFFSET_W'(off)}, $urandom(),
                         1'($urandom_range(0, 1)), fdata);
        end
        send_idle();
        @(negedge clk);
        while (pending != 0) @(posedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && check_count > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
